// File: db_bs.sv
`include "dbsao_cfg.svh"

module db_bs (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      load_i,
  input  dbsao_ctrl_pkg::ctu_info_t ctu_info_i,
  output dbsao_ctrl_pkg::bs_e       bs_o,
  output dbsao_pix_pkg::pixel_t     tc_o
);

  localparam int QW = `DBSAO_QP_W;
  localparam logic [QW-1:0] QP_MIN  = QW'(`DBSAO_TC_QP_MIN);
  localparam logic [QW-1:0] QP_BASE = QW'(`DBSAO_TC_QP_MIN - 2);

  dbsao_ctrl_pkg::bs_e   bs_d;
  dbsao_pix_pkg::pixel_t tc_d;
  logic [QW-1:0]         qp_ofs;

  // intra wins, then coded residue on a transform edge
  always_comb begin
    if (ctu_info_i.mb_type == dbsao_ctrl_pkg::MB_INTRA) begin
      bs_d = dbsao_ctrl_pkg::BS2;
    end else if (ctu_info_i.tu_edge && (ctu_info_i.cbf_p || ctu_info_i.cbf_q)) begin
      bs_d = dbsao_ctrl_pkg::BS1;
    end else begin
      bs_d = dbsao_ctrl_pkg::BS0;
    end
  end

  assign qp_ofs = ctu_info_i.qp - QP_BASE;

  // linear fit of the tc table, one step every two qp
  always_comb begin
    tc_d = '0;
    if (ctu_info_i.qp >= QP_MIN) begin
      tc_d = dbsao_pix_pkg::pixel_t'(qp_ofs >> 1);
      if (bs_d == dbsao_ctrl_pkg::BS2) tc_d = tc_d + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      bs_o <= dbsao_ctrl_pkg::BS0;
      tc_o <= '0;
    end else if (load_i) begin
      bs_o <= bs_d;
      tc_o <= tc_d;
    end
  end

endmodule

// File: db_filter.sv
`include "dbsao_cfg.svh"

module db_filter (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     load_i,
  input  logic                     db_ena_i,
  input  dbsao_ctrl_pkg::bs_e      bs_i,
  input  dbsao_pix_pkg::pixel_t    tc_i,
  input  dbsao_pix_pkg::row_beat_t beat_i,
  output dbsao_pix_pkg::row_beat_t beat_o
);

  localparam int PW = `DBSAO_PIX_W;
  localparam int DW = 14;  // holds 9*255 + 3*255 + 8 with sign
  localparam int EC = `DBSAO_EDGE_COL;

  logic                  db_ena_q;
  dbsao_pix_pkg::pixel_t p1, p0, q0, q1;
  logic signed [DW-1:0]  d_q0p0, d_q1p1, raw, delta, abs_delta;
  logic signed [DW-1:0]  tc_s, tc10, dclip;
  logic signed [PW+1:0]  p0_sum, q0_sum;
  logic                  filt_on;
  dbsao_pix_pkg::row_t   row_f;

  // samples around the edge between columns 3 and 4
  assign p1 = beat_i.pix[EC-2];
  assign p0 = beat_i.pix[EC-1];
  assign q0 = beat_i.pix[EC];
  assign q1 = beat_i.pix[EC+1];

  // ********************
  // normal filter delta
  // ********************
  assign d_q0p0    = $signed(DW'(q0)) - $signed(DW'(p0));
  assign d_q1p1    = $signed(DW'(q1)) - $signed(DW'(p1));
  assign raw       = 14'sd9 * d_q0p0 - 14'sd3 * d_q1p1 + 14'sd8;
  assign delta     = raw >>> 4;
  assign abs_delta = (delta < 0) ? -delta : delta;

  assign tc_s = $signed(DW'(tc_i));
  assign tc10 = tc_s * 14'sd10;  // above this it is a real edge

  assign filt_on = db_ena_q && (bs_i != dbsao_ctrl_pkg::BS0) && (abs_delta < tc10);

  always_comb begin
    if (delta > tc_s) begin
      dclip = tc_s;
    end else if (delta < -tc_s) begin
      dclip = -tc_s;
    end else begin
      dclip = delta;
    end
  end

  assign p0_sum = $signed({2'b00, p0}) + $signed(dclip[PW+1:0]);
  assign q0_sum = $signed({2'b00, q0}) - $signed(dclip[PW+1:0]);

  always_comb begin
    row_f = beat_i.pix;
    if (filt_on) begin
      row_f[EC-1] = dbsao_pix_pkg::clip_pix(p0_sum);
      row_f[EC]   = dbsao_pix_pkg::clip_pix(q0_sum);
    end
  end

  always_ff @(posedge clk) begin
    beat_o.row <= beat_i.row;
    beat_o.pix <= row_f;
    if (!rst_n_i) begin
      db_ena_q   <= 1'b0;
      beat_o.vld <= 1'b0;
    end else begin
      beat_o.vld <= beat_i.vld;
      if (load_i) db_ena_q <= db_ena_i;  // held for the whole block
    end
  end

endmodule

// File: dbsao_cfg.svh
`ifndef DBSAO_CFG_SVH
`define DBSAO_CFG_SVH

// ********************
// block geometry
// ********************
`define DBSAO_PIX_W      8   // bits per luma sample
`define DBSAO_ROW_PIX    8
`define DBSAO_ROWS       8
`define DBSAO_ROW_AW     3
`define DBSAO_EDGE_COL   4   // first q sample of the vertical edge

// ********************
// deblocking and sao
// ********************
`define DBSAO_QP_W       6
`define DBSAO_TC_QP_MIN  18  // tc is zero below this qp
`define DBSAO_BAND_SHIFT 3   // 32 bands
`define DBSAO_OFS_W      4
`define DBSAO_NUM_OFS    4

`endif

// File: dbsao_controller.sv
`include "dbsao_cfg.svh"

module dbsao_controller (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     start_i,
  output logic                     load_o,
  output logic                     rec_ren_o,
  output logic [`DBSAO_ROW_AW-1:0] rec_raddr_o,
  output logic                     rd_vld_o,
  output logic [`DBSAO_ROW_AW-1:0] rd_row_o,
  output logic                     done_o
);

  localparam int AW = `DBSAO_ROW_AW;
  // read data, filter and sao stages still to empty
  localparam logic [AW-1:0] LAST_ROW   = AW'(`DBSAO_ROWS - 1);
  localparam logic [AW-1:0] LAST_DRAIN = AW'(2);

  dbsao_ctrl_pkg::dbsao_state_e state_q, state_d;
  logic [AW-1:0]                cnt_q, cnt_d;
  logic                         done_d;

  assign load_o      = start_i && (state_q == dbsao_ctrl_pkg::IDLE);
  assign rec_ren_o   = (state_q == dbsao_ctrl_pkg::RUN);
  assign rec_raddr_o = cnt_q;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q + 1'b1;
    done_d  = 1'b0;
    case (state_q)
      dbsao_ctrl_pkg::IDLE: begin
        cnt_d = '0;
        if (start_i) state_d = dbsao_ctrl_pkg::RUN;
      end
      dbsao_ctrl_pkg::RUN: begin
        if (cnt_q == LAST_ROW) begin
          state_d = dbsao_ctrl_pkg::DRAIN;
          cnt_d   = '0;
        end
      end
      default: begin  // DRAIN
        if (cnt_q == LAST_DRAIN) begin
          state_d = dbsao_ctrl_pkg::IDLE;
          cnt_d   = '0;
          done_d  = 1'b1;  // last row is on the write port now
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    rd_row_o <= cnt_q;  // tags the data returning next cycle
    if (!rst_n_i) begin
      state_q  <= dbsao_ctrl_pkg::IDLE;
      cnt_q    <= '0;
      rd_vld_o <= 1'b0;
      done_o   <= 1'b0;
    end else begin
      state_q  <= state_d;
      cnt_q    <= cnt_d;
      rd_vld_o <= rec_ren_o;
      done_o   <= done_d;
    end
  end

endmodule

// File: dbsao_ctrl_pkg.sv
`include "dbsao_cfg.svh"

package dbsao_ctrl_pkg;

  typedef enum logic [1:0] {
    IDLE,
    RUN,   // one read per row
    DRAIN  // pipeline emptying
  } dbsao_state_e;

  // two bits leave room for a skip mode
  typedef enum logic [1:0] {
    MB_INTER = 2'd0,
    MB_INTRA = 2'd1
  } mb_type_e;

  typedef enum logic [1:0] {
    BS0,
    BS1,
    BS2
  } bs_e;

  typedef struct packed {
    mb_type_e               mb_type;
    logic                   tu_edge;  // column 4 is a transform edge
    logic                   cbf_p;
    logic                   cbf_q;
    logic [`DBSAO_QP_W-1:0] qp;
  } ctu_info_t;

  typedef logic signed [`DBSAO_OFS_W-1:0] sao_ofs_t;

  // ********************
  // band offset parameters
  // ********************
  typedef struct packed {
    logic [`DBSAO_PIX_W-`DBSAO_BAND_SHIFT-1:0] band_pos;  // first of four bands
    sao_ofs_t [`DBSAO_NUM_OFS-1:0]             ofs;
  } sao_param_t;

endpackage

// File: dbsao_pix_pkg.sv
`include "dbsao_cfg.svh"

package dbsao_pix_pkg;

  typedef logic [`DBSAO_PIX_W-1:0] pixel_t;

  // pixel 0 is the leftmost sample, held in the top bits
  typedef pixel_t [0:`DBSAO_ROW_PIX-1] row_t;

  typedef struct packed {
    logic                     vld;
    logic [`DBSAO_ROW_AW-1:0] row;  // row inside the block
    row_t                     pix;
  } row_beat_t;

  // saturate a widened signed sum back to pixel range
  function automatic pixel_t clip_pix(input logic signed [`DBSAO_PIX_W+1:0] val);
    logic signed [`DBSAO_PIX_W+1:0] max_v;
    max_v = {2'b00, {`DBSAO_PIX_W{1'b1}}};
    if (val < 0) begin
      return '0;
    end else if (val > max_v) begin
      return '1;
    end
    return val[`DBSAO_PIX_W-1:0];
  endfunction

endpackage

// File: dbsao_top.sv
`include "dbsao_cfg.svh"

module dbsao_top (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       start_i,
  input  logic                       db_ena_i,
  input  logic                       sao_ena_i,
  input  dbsao_ctrl_pkg::ctu_info_t  ctu_info_i,
  input  dbsao_ctrl_pkg::sao_param_t sao_param_i,
  output logic                       rec_ren_o,    // reconstruction read
  output logic [`DBSAO_ROW_AW-1:0]   rec_raddr_o,
  input  dbsao_pix_pkg::row_t        rec_rdata_i,  // one cycle after ren
  output logic                       rec_wen_o,    // reconstruction write
  output logic [`DBSAO_ROW_AW-1:0]   rec_waddr_o,
  output dbsao_pix_pkg::row_t        rec_wdata_o,
  output logic                       done_o
);

  logic                     load;
  logic                     rd_vld;
  logic [`DBSAO_ROW_AW-1:0] rd_row;
  dbsao_ctrl_pkg::bs_e      bs;
  dbsao_pix_pkg::pixel_t    tc;
  dbsao_pix_pkg::row_beat_t rd_beat;
  dbsao_pix_pkg::row_beat_t db_beat;

  // read tag joins the returning row
  assign rd_beat = '{vld: rd_vld, row: rd_row, pix: rec_rdata_i};

  dbsao_controller u_controller (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .start_i     (start_i),
    .load_o      (load),
    .rec_ren_o   (rec_ren_o),
    .rec_raddr_o (rec_raddr_o),
    .rd_vld_o    (rd_vld),
    .rd_row_o    (rd_row),
    .done_o      (done_o)
  );

  db_bs u_db_bs (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .load_i     (load),
    .ctu_info_i (ctu_info_i),
    .bs_o       (bs),
    .tc_o       (tc)
  );

  db_filter u_db_filter (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .load_i   (load),
    .db_ena_i (db_ena_i),
    .bs_i     (bs),
    .tc_i     (tc),
    .beat_i   (rd_beat),
    .beat_o   (db_beat)
  );

  sao_bo u_sao_bo (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .load_i      (load),
    .sao_ena_i   (sao_ena_i),
    .sao_param_i (sao_param_i),
    .beat_i      (db_beat),
    .rec_wen_o   (rec_wen_o),
    .rec_waddr_o (rec_waddr_o),
    .rec_wdata_o (rec_wdata_o)
  );

endmodule

// File: run.sh
#!/bin/sh
# compile and run the dbsao testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module tb_dbsao -o tb_dbsao
./obj_dir/tb_dbsao > sim.log 2>&1
cat sim.log
if grep -qx "Finished with no errors" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

// File: sao_bo.sv
`include "dbsao_cfg.svh"

module sao_bo (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       load_i,
  input  logic                       sao_ena_i,
  input  dbsao_ctrl_pkg::sao_param_t sao_param_i,
  input  dbsao_pix_pkg::row_beat_t   beat_i,
  output logic                       rec_wen_o,
  output logic [`DBSAO_ROW_AW-1:0]   rec_waddr_o,
  output dbsao_pix_pkg::row_t        rec_wdata_o
);

  localparam int PW = `DBSAO_PIX_W;
  localparam int BW = `DBSAO_PIX_W - `DBSAO_BAND_SHIFT;
  localparam int IW = $clog2(`DBSAO_NUM_OFS);
  localparam logic [BW-1:0] NUM_OFS = BW'(`DBSAO_NUM_OFS);

  logic                       sao_ena_q;
  dbsao_ctrl_pkg::sao_param_t param_q;
  dbsao_pix_pkg::row_t        row_bo;

  // ********************
  // band offset per pixel
  // ********************
  always_comb begin
    logic [BW-1:0]            k;
    dbsao_ctrl_pkg::sao_ofs_t ofs_k;
    logic signed [PW+1:0]     sum;
    row_bo = beat_i.pix;
    for (int i = 0; i < `DBSAO_ROW_PIX; i++) begin
      // band index relative to band_pos, wraps mod 32
      k     = beat_i.pix[i][PW-1:`DBSAO_BAND_SHIFT] - param_q.band_pos;
      ofs_k = param_q.ofs[k[IW-1:0]];
      sum   = $signed({2'b00, beat_i.pix[i]})
            + $signed({{(PW+2-`DBSAO_OFS_W){ofs_k[`DBSAO_OFS_W-1]}}, ofs_k});
      if (sao_ena_q && (k < NUM_OFS)) begin
        row_bo[i] = dbsao_pix_pkg::clip_pix(sum);
      end
    end
  end

  always_ff @(posedge clk) begin
    rec_waddr_o <= beat_i.row;
    rec_wdata_o <= row_bo;
    if (load_i) param_q <= sao_param_i;
    if (!rst_n_i) begin
      rec_wen_o <= 1'b0;
      sao_ena_q <= 1'b0;
    end else begin
      rec_wen_o <= beat_i.vld;  // memory always accepts
      if (load_i) sao_ena_q <= sao_ena_i;
    end
  end

endmodule

// File: sim.f
+incdir+.
dbsao_pix_pkg.sv
dbsao_ctrl_pkg.sv
dbsao_controller.sv
db_bs.sv
db_filter.sv
sao_bo.sv
dbsao_top.sv
tb_dbsao.sv

// File: tb_dbsao.sv
`include "dbsao_cfg.svh"

module tb_dbsao;

  localparam int CLK_PERIOD = 10;
  localparam int NUM_TESTS  = 6;
  localparam int TEST_CYC   = 40;
  localparam int LATENCY    = 12;  // accepted start to done
  localparam int FILL_RAND  = 0;
  localparam int FILL_EDGE  = 1;
  localparam int FILL_BAND  = 2;
  localparam int PIX_MAX    = (1 << `DBSAO_PIX_W) - 1;

  logic                       clk, rst_n_i, start_i, db_ena_i, sao_ena_i;
  dbsao_ctrl_pkg::ctu_info_t  ctu_info_i;
  dbsao_ctrl_pkg::sao_param_t sao_param_i;
  logic                       rec_ren_o, rec_wen_o, done_o;
  logic [`DBSAO_ROW_AW-1:0]   rec_raddr_o, rec_waddr_o;
  dbsao_pix_pkg::row_t        rec_rdata_i, rec_wdata_o;

  dbsao_pix_pkg::row_t mem [`DBSAO_ROWS];
  dbsao_pix_pkg::row_t exp_mem [`DBSAO_ROWS];
  integer              seed;
  int                  cyc, busy_cnt, wr_cnt, done_cnt, err_cnt, fail_cnt, test_err0;
  logic                accept;
  string               cur_test;

  dbsao_top dut (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .start_i     (start_i),
    .db_ena_i    (db_ena_i),
    .sao_ena_i   (sao_ena_i),
    .ctu_info_i  (ctu_info_i),
    .sao_param_i (sao_param_i),
    .rec_ren_o   (rec_ren_o),
    .rec_raddr_o (rec_raddr_o),
    .rec_rdata_i (rec_rdata_i),
    .rec_wen_o   (rec_wen_o),
    .rec_waddr_o (rec_waddr_o),
    .rec_wdata_o (rec_wdata_o),
    .done_o      (done_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ********************
  // memory model and bookkeeping
  // ********************
  always @(posedge clk) begin
    if (rec_ren_o) rec_rdata_i <= #1 mem[rec_raddr_o];  // synchronous read
    if (rec_wen_o) mem[rec_waddr_o] <= rec_wdata_o;
  end

  // engine is busy from an accepted start up to its done cycle
  assign accept = rst_n_i && start_i && (busy_cnt == 0);

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (rst_n_i && rec_wen_o) wr_cnt <= wr_cnt + 1;
    if (rst_n_i && done_o) done_cnt <= done_cnt + 1;
    if (accept) busy_cnt <= LATENCY - 1;
    else if (busy_cnt != 0) busy_cnt <= busy_cnt - 1;
  end

  // ********************
  // timing checks
  // ********************
  wr_after_rd: assert property (@(posedge clk) disable iff (!rst_n_i || cyc < 16)
      rec_wen_o == $past(rec_ren_o, 3))
    else begin
      err_cnt++;
      $display("%s: write strobe does not follow the read strobe by 3 cycles", cur_test);
    end

  done_lat: assert property (@(posedge clk) disable iff (!rst_n_i || cyc < 16)
      done_o == $past(accept, LATENCY))
    else begin
      err_cnt++;
      $display("%s: done_o is not a single pulse 12 cycles after start", cur_test);
    end

  quiet_rst: assert property (@(posedge clk)
      (!rst_n_i && cyc > 0) |-> !(rec_ren_o || rec_wen_o || done_o))
    else begin
      err_cnt++;
      $display("strobe or done active while reset is held");
    end

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic dbsao_pix_pkg::pixel_t sat_pix(input int v);
    if (v < 0) return '0;
    if (v > PIX_MAX) return '1;
    return dbsao_pix_pkg::pixel_t'(v);
  endfunction

  // expected row: edge filter first, band offset second
  function automatic dbsao_pix_pkg::row_t model_row(input dbsao_pix_pkg::row_t r_in,
      input logic db_en, input logic sao_en, input dbsao_ctrl_pkg::ctu_info_t ctu,
      input dbsao_ctrl_pkg::sao_param_t prm);
    dbsao_pix_pkg::row_t r;
    int bs, tc, p1, p0, q0, q1, d, band, k;
    r  = r_in;
    bs = 0;
    tc = 0;
    if (ctu.mb_type == dbsao_ctrl_pkg::MB_INTRA) bs = 2;
    else if (ctu.tu_edge && (ctu.cbf_p || ctu.cbf_q)) bs = 1;
    if (int'(ctu.qp) >= `DBSAO_TC_QP_MIN) tc = (int'(ctu.qp) - 16) / 2 + ((bs == 2) ? 1 : 0);
    p1 = int'(r[`DBSAO_EDGE_COL-2]);
    p0 = int'(r[`DBSAO_EDGE_COL-1]);
    q0 = int'(r[`DBSAO_EDGE_COL]);
    q1 = int'(r[`DBSAO_EDGE_COL+1]);
    d  = (9 * (q0 - p0) - 3 * (q1 - p1) + 8) >>> 4;
    if (db_en && bs != 0 && ((d < 0) ? -d : d) < 10 * tc) begin
      if (d > tc) d = tc;
      else if (d < -tc) d = -tc;
      r[`DBSAO_EDGE_COL-1] = sat_pix(p0 + d);
      r[`DBSAO_EDGE_COL]   = sat_pix(q0 - d);
    end
    for (int i = 0; i < `DBSAO_ROW_PIX; i++) begin
      band = int'(r[i]) >> `DBSAO_BAND_SHIFT;
      k    = (band - int'(prm.band_pos)) & 31;  // wraps over 32 bands
      if (sao_en && k < `DBSAO_NUM_OFS) r[i] = sat_pix(int'(r[i]) + int'(prm.ofs[k]));
    end
    return r;
  endfunction

  task automatic fill_mem(input int mode);
    logic [31:0] v;
    int          pv;
    for (int r = 0; r < `DBSAO_ROWS; r++) begin
      for (int i = 0; i < `DBSAO_ROW_PIX; i++) begin
        v = rand_word();
        case (mode)
          FILL_EDGE: begin
            if (r % 2 == 1) pv = ((i % 2 == 1) ? 10 : 230) + int'(v[3:0]);  // steep zigzag
            else pv = 100 + int'(v[3:0]) + ((i >= `DBSAO_EDGE_COL) ? 8 * r + 4 : 0);
          end
          FILL_BAND: begin
            case ((r * `DBSAO_ROW_PIX + i) % 5)
              0: pv = 250;
              1: pv = 3;
              2: pv = 244;
              3: pv = 12;
              default: pv = int'(v[7:0]);
            endcase
          end
          default: pv = int'(v[7:0]);
        endcase
        mem[r][i] = dbsao_pix_pkg::pixel_t'(pv);
      end
    end
  endtask

  // one block, entered and left 1 unit after a rising edge
  task automatic run_block(input logic db_en, input logic sao_en,
      input dbsao_ctrl_pkg::ctu_info_t ctu, input dbsao_ctrl_pkg::sao_param_t prm,
      input logic twice);
    int wr0, dn0, w;
    for (int r = 0; r < `DBSAO_ROWS; r++) exp_mem[r] = model_row(mem[r], db_en, sao_en, ctu, prm);
    db_ena_i    = db_en;
    sao_ena_i   = sao_en;
    ctu_info_i  = ctu;
    sao_param_i = prm;
    start_i     = 1'b1;
    @(posedge clk);
    #1 start_i = 1'b0;
    wr0 = wr_cnt;
    dn0 = done_cnt;
    if (twice) begin
      repeat (3) @(posedge clk);
      #1 start_i = 1'b1;  // engine is in RUN here
      @(posedge clk);
      #1 start_i = 1'b0;
    end
    for (w = 0; w < TEST_CYC && !done_o; w++) begin
      @(posedge clk);
      #1;
    end
    assert (done_o) else begin
      err_cnt++;
      $display("%s: done_o did not arrive within %0d cycles", cur_test, TEST_CYC);
    end
    repeat (2) @(posedge clk);
    #1;
    assert (wr_cnt - wr0 == `DBSAO_ROWS) else begin
      err_cnt++;
      $display("Error: %s writes expected %0d actual %0d", cur_test, `DBSAO_ROWS, wr_cnt - wr0);
    end
    assert (done_cnt - dn0 == 1) else begin
      err_cnt++;
      $display("Error: %s done pulses expected 1 actual %0d", cur_test, done_cnt - dn0);
    end
    for (int r = 0; r < `DBSAO_ROWS; r++) begin
      assert (mem[r] === exp_mem[r]) else begin
        err_cnt++;
        $display("Error: %s row %0d expected %h actual %h", cur_test, r, exp_mem[r], mem[r]);
      end
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_err0 = err_cnt;
  endtask

  task automatic end_test();
    if (err_cnt == test_err0) begin
      $display("test %s: ok", cur_test);
    end else begin
      fail_cnt++;
      $display("test %s: failed, %0d errors", cur_test, err_cnt - test_err0);
    end
  endtask

  initial begin
    #(NUM_TESTS * TEST_CYC * CLK_PERIOD);
    $display("run timed out after %0d time units", NUM_TESTS * TEST_CYC * CLK_PERIOD);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    dbsao_ctrl_pkg::ctu_info_t  ctu;
    dbsao_ctrl_pkg::sao_param_t prm;
    logic [31:0]                v;
    seed        = 85;
    cur_test    = "reset";
    rst_n_i     = 1'b0;
    start_i     = 1'b0;
    db_ena_i    = 1'b0;
    sao_ena_i   = 1'b0;
    ctu_info_i  = '0;
    sao_param_i = '0;
    rec_rdata_i = '0;
    repeat (8) @(posedge clk);
    #1 rst_n_i = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    prm.band_pos = 5'd12;  // live offsets, sao stays off until band_offset
    prm.ofs      = {4'sd3, -4'sd2, 4'sd5, -4'sd6};

    begin_test("bypass");
    fill_mem(FILL_RAND);
    ctu = '{dbsao_ctrl_pkg::MB_INTRA, 1'b1, 1'b1, 1'b1, 6'd30};
    run_block(1'b0, 1'b0, ctu, prm, 1'b0);
    end_test();

    begin_test("intra_edge");
    fill_mem(FILL_EDGE);
    ctu = '{dbsao_ctrl_pkg::MB_INTRA, 1'b0, 1'b0, 1'b0, 6'd37};
    run_block(1'b1, 1'b0, ctu, prm, 1'b0);
    end_test();

    begin_test("bs_zero_bs1");
    fill_mem(FILL_EDGE);
    ctu = '{dbsao_ctrl_pkg::MB_INTER, 1'b1, 1'b0, 1'b0, 6'd37};  // no residue, bs 0
    run_block(1'b1, 1'b0, ctu, prm, 1'b0);
    fill_mem(FILL_EDGE);
    ctu = '{dbsao_ctrl_pkg::MB_INTER, 1'b1, 1'b0, 1'b1, 6'd37};
    run_block(1'b1, 1'b0, ctu, prm, 1'b0);
    end_test();

    begin_test("band_offset");
    fill_mem(FILL_BAND);
    prm.band_pos = 5'd30;  // bands 30, 31, 0, 1
    prm.ofs      = {-4'sd1, -4'sd8, 4'sd7, 4'sd7};
    run_block(1'b0, 1'b1, ctu, prm, 1'b0);
    end_test();

    begin_test("combined_random");
    fill_mem(FILL_RAND);
    v            = rand_word();
    ctu          = '{dbsao_ctrl_pkg::MB_INTRA, v[31], v[30], v[29], 6'd18 + 6'(v[28:24])};
    prm.band_pos = v[20:16];
    prm.ofs      = v[15:0];
    run_block(1'b1, 1'b1, ctu, prm, 1'b0);
    end_test();

    begin_test("busy_start");
    fill_mem(FILL_RAND);
    run_block(1'b1, 1'b1, ctu, prm, 1'b1);
    end_test();

    $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
